// File: verilog.f
verilog/params_pkg.sv
verilog/le_types_pkg.sv
verilog/oht_channel.sv
verilog/source_select.sv
verilog/bit_packer.sv
verilog/entropy_top.sv
verif/entropy_tb.sv

// File: Bender.yml
package:
  name: entropy_frontend

sources:
  # packages first, the type package depends on the parameter package
  - files:
      - verilog/params_pkg.sv
      - verilog/le_types_pkg.sv

  # health tests, selector, packer and top level
  - files:
      - verilog/oht_channel.sv
      - verilog/source_select.sv
      - verilog/bit_packer.sv
      - verilog/entropy_top.sv

  # testbench
  - target: test
    files:
      - verif/entropy_tb.sv

// File: verif/entropy_tb.sv
`default_nettype none

module entropy_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int pat_alt  = 0;
    localparam int pat_one  = 1;
    localparam int pat_bias = 2;

    logic                                            clk = 1'b0;
    logic                                            rst;
    logic [params_pkg::num_src-1:0]                  adc_in = '0;
    logic                                            debug_mode;
    le_types_pkg::health_t [params_pkg::num_src-1:0] status;
    logic                                            word_valid;
    le_types_pkg::word_t                             word;

    // stimulus state
    int          pat   [params_pkg::num_src];
    int unsigned phase [params_pkg::num_src];
    int unsigned step  [params_pkg::num_src] = '{default: 0};
    logic        quiet;
    string       test_name = "reset";

    // reference model state
    le_types_pkg::health_t [params_pkg::num_src-1:0] m_status;
    int                             m_run  [params_pkg::num_src];
    int                             m_fail [params_pkg::num_src];
    int                             m_win  [params_pkg::num_src];
    int                             m_ones [params_pkg::num_src];
    logic [params_pkg::num_src-1:0] m_samp;
    logic                           m_wv;
    le_types_pkg::word_t            m_word;
    logic                           q_bits [$];
    int                             pulses;

    entropy_top DUT (
        .clk        (clk),
        .rst        (rst),
        .adc_in     (adc_in),
        .debug_mode (debug_mode),
        .status     (status),
        .word_valid (word_valid),
        .word       (word)
    );

    always #4 clk = ~clk;

    function automatic logic pattern_bit(input int mode, input int unsigned n);
        case (mode)
            pat_alt: return n[0];
            pat_one: return 1'b1;
            // one zero in every eight samples
            default: return (n % 8) != 0;
        endcase
    endfunction

    always @(posedge clk) begin
        for (int i = 0; i < params_pkg::num_src; i++) begin
            adc_in[i] <= pattern_bit(pat[i], step[i] + phase[i]);
            step[i]   <= step[i] + 1;
        end
    end

    task automatic report_mismatch(input string check, input logic [63:0] exp,
                                   input logic [63:0] act);
        $display("FAIL %s %s expected %0h actual %0h", test_name, check, exp, act);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic report_timeout(input string what);
        $display("timeout in %s while waiting for %s", test_name, what);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    // repetition and proportion rules for one source
    task automatic channel_step(input int s, input logic b);
        int   r;
        int   n;
        int   o;
        logic hit_i;
        logic hit_p;
        r = (m_run[s] == 0 || b != m_samp[s]) ? 1 : m_run[s] + 1;
        if (!m_status[s].perm_fail) begin
            hit_i = (r == params_pkg::rep_inter) && (m_fail[s] < params_pkg::inter_max);
            hit_p = (r == params_pkg::rep_perm) && (m_fail[s] == params_pkg::inter_max);
            m_status[s].inter_fail = hit_i;
            if (hit_p) begin
                m_status[s].perm_fail = 1'b1;
            end
            if (hit_i) begin
                m_run[s]  = 0;
                m_fail[s] = m_fail[s] + 1;
                m_win[s]  = 0;
                m_ones[s] = 0;
            end else begin
                m_run[s] = r;
                n = m_win[s] + 1;
                o = m_ones[s] + b;
                if (n == params_pkg::window_len) begin
                    if (o >= params_pkg::prop_lo && o <= params_pkg::prop_hi) begin
                        m_status[s].valid = 1'b1;
                    end
                    m_win[s]  = 0;
                    m_ones[s] = 0;
                end else begin
                    m_win[s]  = n;
                    m_ones[s] = o;
                end
            end
        end
    endtask

    // expected selection and word assembly
    task automatic select_and_pack();
        logic                             take;
        logic                             b;
        logic                             dbg;
        logic [params_pkg::word_bits-1:0] data;
        take = 1'b0;
        b    = 1'b0;
        dbg  = 1'b0;
        m_wv = 1'b0;
        if (debug_mode) begin
            take = 1'b1;
            b    = m_samp[0];
            dbg  = 1'b1;
        end else begin
            for (int i = 0; i < params_pkg::num_src; i++) begin
                if (!take && m_status[i].valid && !m_status[i].inter_fail
                        && !m_status[i].perm_fail) begin
                    take = 1'b1;
                    b    = m_samp[i];
                end
            end
        end
        if (take) begin
            q_bits.push_back(b);
            if (q_bits.size() == params_pkg::word_bits) begin
                for (int k = 0; k < params_pkg::word_bits; k++) begin
                    data[params_pkg::word_bits-1-k] = q_bits[k];
                end
                m_word = '{debug: dbg, data: data};
                m_wv   = 1'b1;
                q_bits.delete();
            end
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            m_status = '0;
            m_wv     = 1'b0;
            m_word   = '0;
            q_bits.delete();
            for (int i = 0; i < params_pkg::num_src; i++) begin
                m_run[i]  = 0;
                m_fail[i] = 0;
                m_win[i]  = 0;
                m_ones[i] = 0;
            end
        end else begin
            select_and_pack();
            for (int i = 0; i < params_pkg::num_src; i++) begin
                channel_step(i, adc_in[i]);
            end
        end
        m_samp = adc_in;
    end

    reset_state: assert property (@(posedge clk)
        $fell(rst) |-> (word_valid == 1'b0 && word == '0 && status == '0))
        else report_mismatch("reset_state", 64'd0,
                             {$sampled(word_valid), $sampled(word), $sampled(status)});

    for (genvar i = 0; i < params_pkg::num_src; i++) begin : g_chk
        valid_match: assert property (@(posedge clk) disable iff (rst)
            status[i].valid == m_status[i].valid)
            else report_mismatch("valid", $sampled(m_status[i].valid),
                                 $sampled(status[i].valid));
        inter_match: assert property (@(posedge clk) disable iff (rst)
            status[i].inter_fail == m_status[i].inter_fail)
            else report_mismatch("inter_fail", $sampled(m_status[i].inter_fail),
                                 $sampled(status[i].inter_fail));
        perm_match: assert property (@(posedge clk) disable iff (rst)
            status[i].perm_fail == m_status[i].perm_fail)
            else report_mismatch("perm_fail", $sampled(m_status[i].perm_fail),
                                 $sampled(status[i].perm_fail));
    end

    strobe_match: assert property (@(posedge clk) disable iff (rst) word_valid == m_wv)
        else report_mismatch("word_valid", $sampled(m_wv), $sampled(word_valid));

    word_match: assert property (@(posedge clk) disable iff (rst)
        word_valid |-> word == m_word)
        else report_mismatch("word", $sampled(m_word), $sampled(word));

    no_word: assert property (@(posedge clk) disable iff (rst) quiet |-> !word_valid)
        else report_mismatch("no_word", 64'd0, $sampled(word_valid));

    task automatic apply_reset();
        rst <= 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
    endtask

    task automatic set_pattern(input int s, input int mode);
        pat[s] <= mode;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) @(posedge clk);
    endtask

    task automatic wait_valid(input int s, input int limit);
        int n;
        n = 0;
        while (!status[s].valid) begin
            if (n == limit) begin
                report_timeout($sformatf("valid on source %0d", s));
            end else begin
                @(posedge clk);
                n++;
            end
        end
    endtask

    task automatic wait_words(input int count, input int limit);
        int seen;
        int n;
        seen = 0;
        n    = 0;
        while (seen < count) begin
            if (n == limit) begin
                report_timeout("word_valid");
            end else begin
                @(posedge clk);
                n++;
                if (word_valid) begin
                    seen++;
                end
            end
        end
    endtask

    // counts intermittent pulses on the way to the permanent failure
    task automatic wait_perm(input int s, input int limit, output int hits);
        int n;
        n    = 0;
        hits = 0;
        while (!status[s].perm_fail) begin
            if (n == limit) begin
                report_timeout($sformatf("perm_fail on source %0d", s));
            end else begin
                @(posedge clk);
                n++;
                if (status[s].inter_fail) begin
                    hits++;
                end
            end
        end
    endtask

    initial begin
        void'($urandom(90));
        rst        <= 1'b1;
        debug_mode <= 1'b0;
        quiet      <= 1'b0;
        for (int i = 0; i < params_pkg::num_src; i++) begin
            pat[i]   <= pat_alt;
            // parity follows the index so alternating neighbours never match
            phase[i] = 2 * ($urandom % 4) + i;
        end
        apply_reset();

        test_name = "pass_window";
        wait_valid(0, 2 * params_pkg::window_len);
        wait_words(3, 4 * params_pkg::word_bits);

        test_name = "stuck_one";
        set_pattern(0, pat_one);
        wait_perm(0, params_pkg::inter_max * params_pkg::rep_inter
                     + 2 * params_pkg::rep_perm, pulses);
        inter_count: assert (pulses == params_pkg::inter_max)
            else report_mismatch("inter_count", params_pkg::inter_max, pulses);

        // source 1 carries the words from here on
        test_name = "failover";
        wait_words(3, 4 * params_pkg::word_bits);

        test_name = "proportion";
        set_pattern(0, pat_bias);
        set_pattern(1, pat_one);
        apply_reset();
        quiet <= 1'b1;
        idle(3 * params_pkg::window_len);
        quiet <= 1'b0;
        valid_low: assert (status[0].valid == 1'b0)
            else report_mismatch("valid_low", 64'd0, status[0].valid);

        test_name = "debug";
        debug_mode <= 1'b1;
        wait_words(3, 4 * params_pkg::word_bits);

        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/entropy_top.sv
`default_nettype none

module entropy_top (
    input  wire                                            clk,
    input  wire                                            rst,
    input  wire [params_pkg::num_src-1:0]                  adc_in,
    input  wire                                            debug_mode,
    output le_types_pkg::health_t [params_pkg::num_src-1:0] status,
    output logic                                           word_valid,
    output le_types_pkg::word_t                            word
);

    logic [params_pkg::num_src-1:0] chan_disable;
    logic [params_pkg::num_src-1:0] chan_sample;
    logic                           take;
    logic                           sel_bit;
    logic                           sel_dbg;

    // one health test per source
    for (genvar i = 0; i < params_pkg::num_src; i++) begin : g_chan
        oht_channel u_chan (
            .clk         (clk),
            .rst         (rst),
            .adc_in      (adc_in[i]),
            .health      (status[i]),
            .src_disable (chan_disable[i]),
            .sample      (chan_sample[i])
        );
    end

    source_select u_select (
        .health      (status),
        .src_disable (chan_disable),
        .sample      (chan_sample),
        .debug_mode  (debug_mode),
        .take        (take),
        .data_bit    (sel_bit),
        .dbg         (sel_dbg)
    );

    bit_packer u_packer (
        .clk        (clk),
        .rst        (rst),
        .take       (take),
        .data_bit   (sel_bit),
        .dbg        (sel_dbg),
        .word_valid (word_valid),
        .word       (word)
    );

endmodule

`default_nettype wire

// File: verilog/bit_packer.sv
`default_nettype none

module bit_packer (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 take,
    input  wire                 data_bit,
    input  wire                 dbg,
    output logic                word_valid,
    output le_types_pkg::word_t word
);

    logic [params_pkg::word_bits-1:0] shift_q;
    logic [params_pkg::word_bits-1:0] shift_nxt;
    logic [params_pkg::cnt_w-1:0]     bit_cnt;

    // first accepted bit ends up in the msb
    assign shift_nxt = {shift_q[params_pkg::word_bits-2:0], data_bit};

    always_ff @(posedge clk) begin
        if (take) begin
            shift_q <= shift_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bit_cnt    <= '0;
            word_valid <= 1'b0;
            word       <= '0;
        end else begin
            word_valid <= 1'b0;
            if (take) begin
                // count wraps back to zero after the last bit
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == params_pkg::word_bits - 1) begin
                    word       <= '{debug: dbg, data: shift_nxt};
                    word_valid <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/source_select.sv
`default_nettype none

module source_select (
    input  wire le_types_pkg::health_t [params_pkg::num_src-1:0] health,
    input  wire [params_pkg::num_src-1:0]                        src_disable,
    input  wire [params_pkg::num_src-1:0]                        sample,
    input  wire                                                  debug_mode,
    output logic                                                 take,
    output logic                                                 data_bit,
    output logic                                                 dbg
);

    always_comb begin
        take     = 1'b0;
        data_bit = 1'b0;
        dbg      = 1'b0;
        if (debug_mode) begin
            // raw bits from source 0, health ignored
            take     = 1'b1;
            data_bit = sample[0];
            dbg      = 1'b1;
        end else begin
            // walk downwards so the lowest healthy index wins
            for (int i = params_pkg::num_src - 1; i >= 0; i--) begin
                if (health[i].valid && !src_disable[i]) begin
                    take     = 1'b1;
                    data_bit = sample[i];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/oht_channel.sv
`default_nettype none

module oht_channel (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   adc_in,
    output le_types_pkg::health_t health,
    output logic                  src_disable,
    output logic                  sample
);

    logic [params_pkg::run_w-1:0]  run_cnt;
    logic [params_pkg::run_w-1:0]  run_nxt;
    logic [params_pkg::fail_w-1:0] fail_cnt;
    logic [params_pkg::win_w-1:0]  win_cnt;
    logic [params_pkg::ones_w-1:0] ones_cnt;
    logic [params_pkg::ones_w-1:0] ones_nxt;
    logic                          inter_hit;
    logic                          perm_hit;
    logic                          win_end;
    logic                          band_ok;
    logic                          valid_q;
    logic                          inter_q;
    logic                          perm_q;

    // sample seen by the selector one cycle later
    always_ff @(posedge clk) begin
        sample <= adc_in;
    end

    // run length including the sample now on adc_in
    always_comb begin
        if (run_cnt == '0 || adc_in != sample) begin
            run_nxt = 1'b1;
        end else begin
            run_nxt = run_cnt + 1'b1;
        end
    end

    assign inter_hit = (run_nxt == params_pkg::rep_inter)
                     && (fail_cnt < params_pkg::inter_max);
    assign perm_hit  = (run_nxt == params_pkg::rep_perm)
                     && (fail_cnt == params_pkg::inter_max);

    // repetition count, intermittent then permanent failures
    always_ff @(posedge clk) begin
        if (rst) begin
            run_cnt  <= '0;
            fail_cnt <= '0;
            inter_q  <= 1'b0;
            perm_q   <= 1'b0;
        end else if (!perm_q) begin
            inter_q <= inter_hit;
            if (perm_hit) begin
                perm_q <= 1'b1;
            end
            if (inter_hit) begin
                // restart the run after each intermittent failure
                run_cnt  <= '0;
                fail_cnt <= fail_cnt + 1'b1;
            end else begin
                run_cnt <= run_nxt;
            end
        end
    end

    assign ones_nxt = ones_cnt + adc_in;
    assign win_end  = (win_cnt == params_pkg::window_len - 1);
    assign band_ok  = (ones_nxt >= params_pkg::prop_lo)
                    && (ones_nxt <= params_pkg::prop_hi);

    // proportion window over window_len samples
    always_ff @(posedge clk) begin
        if (rst) begin
            win_cnt  <= '0;
            ones_cnt <= '0;
            valid_q  <= 1'b0;
        end else if (!perm_q) begin
            if (inter_hit) begin
                win_cnt  <= '0;
                ones_cnt <= '0;
            end else if (win_end) begin
                if (band_ok) begin
                    valid_q <= 1'b1;
                end
                win_cnt  <= '0;
                ones_cnt <= '0;
            end else begin
                win_cnt  <= win_cnt + 1'b1;
                ones_cnt <= ones_nxt;
            end
        end
    end

    assign health = '{valid: valid_q, inter_fail: inter_q, perm_fail: perm_q};

    // keeps the selector off this source
    assign src_disable = inter_q | perm_q;

endmodule

`default_nettype wire

// File: verilog/le_types_pkg.sv
`default_nettype none

package le_types_pkg;

    // health record for one entropy source
    typedef struct packed {
        // sticky, set by the first passing proportion window
        logic valid;
        // one cycle pulse per repetition failure
        logic inter_fail;
        // sticky until reset
        logic perm_fail;
    } health_t;

    // packed output word
    typedef struct packed {
        // word was assembled in debug mode
        logic                             debug;
        logic [params_pkg::word_bits-1:0] data;
    } word_t;

endpackage

`default_nettype wire

// File: verilog/params_pkg.sv
`default_nettype none

package params_pkg;

    localparam int num_src    = 2;

    // proportion test
    localparam int window_len = 1024;
    localparam int prop_lo    = 461;
    localparam int prop_hi    = 562;

    // repetition count test
    localparam int rep_inter  = 20;
    localparam int rep_perm   = 30;
    localparam int inter_max  = 3;

    localparam int word_bits  = 32;

    // counter widths
    localparam int run_w      = $clog2(rep_perm + 1);
    localparam int fail_w     = $clog2(inter_max + 1);
    localparam int win_w      = $clog2(window_len);
    localparam int ones_w     = $clog2(window_len + 1);
    localparam int cnt_w      = $clog2(word_bits);

endpackage

`default_nettype wire
